//--- tests/burst_input.txt
# latency corrupt_burst corrupt_lane xor_mask (hex)
# latency 0 is random 1..15, corrupt_burst -1 is a clean run
3 -1 0 0000
0 -1 0 0000
1 -1 0 0000
12 -1 0 0000
7 2 1 0100
0 4 3 8000
2 1 2 0001
0 3 0 0080
5 0 0 ffff
1 5 3 0010
0 5 0 0200
4 0 3 00ff

//--- build.f
rtl/sdram_test_pkg.sv
rtl/word_check_lane.sv
rtl/report_serializer.sv
rtl/burst_sequencer.sv
rtl/sdram_burst_test.sv
tests/sdram_model.sv
tests/tb_sdram_burst_test.sv

//--- Bender.yml
package:
  name: sdram_burst_test

sources:
  # Design.
  - rtl/sdram_test_pkg.sv
  - rtl/word_check_lane.sv
  - rtl/report_serializer.sv
  - rtl/burst_sequencer.sv
  - rtl/sdram_burst_test.sv

  # Testbench.
  - target: test
    files:
      - tests/sdram_model.sv
      - tests/tb_sdram_burst_test.sv

//--- tests/tb_sdram_burst_test.sv
`timescale 1ns/1ps

module tb_sdram_burst_test
    import sdram_test_pkg::*;
;

    localparam int FRAME_BURSTS = 6;
    localparam int BAUD_DIV     = 8;
    localparam int PAUSE_CYCLES = 20;
    localparam int FRAME_CYC    = UART_FRAME_BITS * BAUD_DIV;
    localparam int QUIET_CYC    = 3 * PAUSE_CYCLES + FRAME_CYC;

    logic clk_133MHz_210 = 1'b0;
    logic rst_n = 1'b1;
    logic wr_req, rd_req, wr_done, rd_done, uart_txd, led;
    addr_t addr;
    word_t wr_data [NUM_LANES];
    word_t rd_data [NUM_LANES];
    int latency = 1, corrupt_burst = -1, corrupt_lane = 0;
    word_t corrupt_mask = '0;

    int errors = 0, checks = 0, n_bursts = 0;
    logic wr_req_q = 1'b0;
    logic [7:0] rx_q [$];
    logic [7:0] exp_q [$];
    logic [7:0] ref_q [$];
    bit ref_valid = 0;

    logic rx_busy = 1'b0;   // UART receiver state.
    int rx_cnt = 0;
    logic [7:0] rx_byte;

    always #2 clk_133MHz_210 = ~clk_133MHz_210;   // 4 ns period.

    sdram_burst_test #(.FRAME_BURSTS(FRAME_BURSTS), .BAUD_DIV(BAUD_DIV),
        .PAUSE_CYCLES(PAUSE_CYCLES)) UUT (.*);

    sdram_model u_mem (.clk(clk_133MHz_210), .*);

    ////////////////////////////////////////////////////////////////////////////
    // UART receiver, samples mid bit.
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk_133MHz_210) begin
        if (!rst_n) begin
            rx_busy = 1'b0;
        end else if (!rx_busy) begin
            if (!uart_txd) begin
                rx_busy = 1'b1;     // Start bit seen.
                rx_cnt = 0;
            end
        end else begin
            rx_cnt++;
            for (int b = 0; b < 8; b++)
                if (rx_cnt == BAUD_DIV * (b + 1) + BAUD_DIV / 2 - 1) rx_byte[b] = uart_txd;
            if (rx_cnt == BAUD_DIV * 9 + BAUD_DIV / 2 - 1) begin
                checks++;
                if (!uart_txd) begin
                    errors++;
                    $display("mismatch at %0t: UART stop bit low", $time);
                end
                rx_q.push_back(rx_byte);
                rx_busy = 1'b0;
            end
        end
    end

    // Write-time check of address and test words.
    always @(posedge clk_133MHz_210) begin
        if (rst_n && wr_req && !wr_req_q) begin
            checks++;
            if (addr != addr_t'(NUM_LANES * n_bursts)) begin
                errors++;
                $display("mismatch at %0t: addr %0h, expected %0h", $time, addr,
                         NUM_LANES * n_bursts);
            end
            foreach (wr_data[i])
                if (wr_data[i] != word_t'(n_bursts)) begin
                    errors++;
                    $display("mismatch at %0t: wr_data[%0d] %0h, expected %0h",
                             $time, i, wr_data[i], n_bursts);
                end
            n_bursts++;
        end
        wr_req_q = rst_n && wr_req;
    end

    task automatic apply_reset();
        bit bad;
        #1;
        rst_n = 1'b0;                       // Falling edge, 1 ns into the cycle.
        #0.5;
        checks++;
        bad = (wr_req !== 1'b0) || (rd_req !== 1'b0) || (led !== 1'b0) ||
              (uart_txd !== 1'b1) || (addr !== '0);
        foreach (wr_data[i])
            if (wr_data[i] !== '0) bad = 1'b1;
        if (bad) begin
            errors++;
            $display("mismatch at %0t: outputs not in reset state", $time);
        end
        rx_q.delete();
        n_bursts = 0;
        repeat (3) @(posedge clk_133MHz_210);
        #1;
        rst_n = 1'b1;
    endtask

    // Bytes the plan's rules give for this run.
    task automatic fill_expected();
        int last;
        exp_q.delete();
        last = (corrupt_burst < 0) ? FRAME_BURSTS - 1 : corrupt_burst;
        for (int n = 0; n <= last; n++)
            for (int k = 0; k < NUM_LANES; k++) begin
                if (n == corrupt_burst && k == corrupt_lane) begin
                    if (corrupt_mask[15:8] != 0) begin
                        exp_q.push_back(ERR_HI_CODE);
                    end else begin
                        exp_q.push_back(n[15:8]);
                        exp_q.push_back(ERR_LO_CODE);
                    end
                    return;
                end
                exp_q.push_back(n[15:8]);
                exp_q.push_back(n[7:0]);
            end
    endtask

    task automatic wait_bytes(int count);
        int cyc = 0;
        while (rx_q.size() < count && cyc < 40000) begin
            @(posedge clk_133MHz_210);
            cyc++;
        end
        if (rx_q.size() < count) begin
            errors++;
            $display("Timed out waiting for %0d UART bytes, got %0d", count, rx_q.size());
        end
    endtask

    task automatic wait_led();
        int cyc = 0;
        while (!led && cyc < 4 * FRAME_CYC) begin
            @(posedge clk_133MHz_210);
            cyc++;
        end
        if (!led) begin
            errors++;
            $display("Timed out waiting for the error led");
        end
    endtask

    // No requests, no bytes and a steady led for a while.
    task automatic check_quiet(logic led_exp);
        int size0 = rx_q.size();
        bit bad = 0;
        for (int c = 0; c < QUIET_CYC; c++) begin
            @(posedge clk_133MHz_210);
            if (wr_req || rd_req || led != led_exp) bad = 1;
        end
        checks++;
        if (bad || rx_q.size() != size0) begin
            errors++;
            $display("mismatch at %0t: activity after end, led expected %0b", $time, led_exp);
        end
    endtask

    task automatic compare_stream(input logic [7:0] want [$], input string what);
        checks++;
        if (rx_q.size() != want.size()) begin
            errors++;
            $display("mismatch at %0t: %0d bytes, %s has %0d", $time, rx_q.size(),
                     what, want.size());
        end
        for (int i = 0; i < rx_q.size() && i < want.size(); i++)
            if (rx_q[i] != want[i]) begin
                errors++;
                $display("mismatch at %0t: byte %0d is %0h, %s has %0h", $time, i,
                         rx_q[i], what, want[i]);
            end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Runs from the data file.
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int fd;
        string line;
        int rc;
        fd = $fopen("tests/burst_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open tests/burst_input.txt");
        end else begin
            while ($fgets(line, fd)) begin
                if (line.len() < 3 || line[0] == "#") continue;
                rc = $sscanf(line, "%d %d %d %h", latency, corrupt_burst, corrupt_lane,
                             corrupt_mask);
                if (rc != 4) begin
                    errors++;
                    $display("Could not read four fields from line: %s", line);
                    continue;
                end
                apply_reset();
                fill_expected();
                wait_bytes(exp_q.size());
                if (corrupt_burst >= 0) wait_led();
                check_quiet(corrupt_burst >= 0);
                compare_stream(exp_q, "expected");
                checks++;
                if (n_bursts != ((corrupt_burst < 0) ? FRAME_BURSTS : corrupt_burst + 1)) begin
                    errors++;
                    $display("mismatch at %0t: %0d bursts written", $time, n_bursts);
                end
                if (corrupt_burst < 0 && ref_valid) compare_stream(ref_q, "first clean run");
                if (corrupt_burst < 0 && !ref_valid) begin
                    ref_q = rx_q;   // Reference for the latency runs.
                    ref_valid = 1;
                end
            end
            $fclose(fd);
        end
        $display("errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- tests/sdram_model.sv
`timescale 1ns/1ps

module sdram_model
    import sdram_test_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  wr_req,
    input  logic  rd_req,
    input  addr_t addr,
    input  word_t wr_data [NUM_LANES],
    input  int    latency,          // 0 picks a random latency.
    input  int    corrupt_burst,    // -1 for a clean run.
    input  int    corrupt_lane,
    input  word_t corrupt_mask,
    output logic  wr_done,
    output logic  rd_done,
    output word_t rd_data [NUM_LANES]
);

    word_t mem [int];   // Sparse storage by word address.
    int    wait_cycles;
    int    a;

    initial begin
        void'($urandom(92652));     // Seed for the latency draws.
        wr_done = 1'b0;
        rd_done = 1'b0;
        foreach (rd_data[i]) rd_data[i] = '0;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && (wr_req || rd_req)) begin
                wait_cycles = (latency == 0) ? $urandom_range(15, 1) : latency;
                repeat (wait_cycles) @(posedge clk);
                #1;
                a = int'(addr);
                if (wr_req) begin
                    foreach (wr_data[i]) mem[a + i] = wr_data[i];
                    wr_done = 1'b1;
                end else begin
                    foreach (rd_data[i]) begin
                        rd_data[i] = mem.exists(a + i) ? mem[a + i] : '0;
                        if (a / NUM_LANES == corrupt_burst && i == corrupt_lane)
                            rd_data[i] = rd_data[i] ^ corrupt_mask;   // Injected fault.
                    end
                    rd_done = 1'b1;
                end
                @(posedge clk);
                #1;
                wr_done = 1'b0;     // One-cycle pulse.
                rd_done = 1'b0;
            end
        end
    end

endmodule

//--- rtl/sdram_burst_test.sv
`timescale 1ns/1ps

module sdram_burst_test
    import sdram_test_pkg::*;
#(
    parameter int FRAME_BURSTS = 96000,     // 384000 words / 4.
    parameter int BAUD_DIV     = 1157,      // 133.33 MHz / 115200.
    parameter int PAUSE_CYCLES = 2222222
) (
    input  logic  clk_133MHz_210,
    input  logic  rst_n,

    // SDRAM controller port.
    output logic  wr_req,
    output logic  rd_req,
    output addr_t addr,
    output word_t wr_data [NUM_LANES],
    input  logic  wr_done,
    input  logic  rd_done,
    input  word_t rd_data [NUM_LANES],

    output logic  uart_txd,
    output logic  led
);

    logic                 advance;
    logic                 report_start;
    logic                 report_done;
    logic                 report_fail;
    word_t                back_words [NUM_LANES];   // Captured read-back.
    logic [NUM_LANES-1:0] hi_match;
    logic [NUM_LANES-1:0] lo_match;

    ////////////////////////////////////////////////////////////////////////////
    // Write, read, report and pause control.
    ////////////////////////////////////////////////////////////////////////////
    burst_sequencer #(
        .FRAME_BURSTS (FRAME_BURSTS),
        .PAUSE_CYCLES (PAUSE_CYCLES)
    ) u_seq (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .wr_done        (wr_done),
        .rd_done        (rd_done),
        .report_done    (report_done),
        .report_fail    (report_fail),
        .wr_req         (wr_req),
        .rd_req         (rd_req),
        .addr           (addr),
        .advance        (advance),
        .report_start   (report_start),
        .led            (led)
    );

    // One lane per burst word.
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        word_check_lane u_lane (
            .clk_133MHz_210 (clk_133MHz_210),
            .rst_n          (rst_n),
            .advance        (advance),
            .rd_done        (rd_done),
            .rd_word        (rd_data[g]),
            .wr_word        (wr_data[g]),
            .back_word      (back_words[g]),
            .hi_match       (hi_match[g]),
            .lo_match       (lo_match[g])
        );
    end

    // UART report of the burst.
    report_serializer #(
        .BAUD_DIV (BAUD_DIV)
    ) u_report (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .report_start   (report_start),
        .back_words     (back_words),
        .hi_match       (hi_match),
        .lo_match       (lo_match),
        .report_done    (report_done),
        .report_fail    (report_fail),
        .uart_txd       (uart_txd)
    );

endmodule

//--- rtl/burst_sequencer.sv
`timescale 1ns/1ps

module burst_sequencer
    import sdram_test_pkg::*;
#(
    parameter int FRAME_BURSTS = 96000,     // Bursts per frame.
    parameter int PAUSE_CYCLES = 2222222    // Gap between bursts.
) (
    input  logic  clk_133MHz_210,
    input  logic  rst_n,
    input  logic  wr_done,          // Controller write done pulse.
    input  logic  rd_done,          // Controller read done pulse.
    input  logic  report_done,
    input  logic  report_fail,
    output logic  wr_req,
    output logic  rd_req,
    output addr_t addr,
    output logic  advance,          // Lanes step their test word.
    output logic  report_start,
    output logic  led               // Error indicator.
);

    localparam int BURST_W = $clog2(FRAME_BURSTS + 1);
    localparam int PAUSE_W = $clog2(PAUSE_CYCLES + 1);

    localparam logic [BURST_W-1:0] LAST_BURST = BURST_W'(FRAME_BURSTS - 1);
    localparam logic [PAUSE_W-1:0] PAUSE_LAST = PAUSE_W'(PAUSE_CYCLES - 1);

    seq_state_t         state;
    logic [BURST_W-1:0] burst_cnt;  // Bursts finished in this frame.
    logic [PAUSE_W-1:0] pause_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // Main FSM.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_WRITE;
            wr_req       <= 1'b0;
            rd_req       <= 1'b0;
            addr         <= '0;
            advance      <= 1'b0;
            report_start <= 1'b0;
            led          <= 1'b0;
            burst_cnt    <= '0;
            pause_cnt    <= '0;
        end else begin
            advance      <= 1'b0;       // Strobes default low.
            report_start <= 1'b0;
            case (state)
                ST_WRITE: begin
                    // Request held until the controller answers.
                    if (wr_done) begin
                        wr_req <= 1'b0;
                        state  <= ST_READ;
                    end else begin
                        wr_req <= 1'b1;
                    end
                end

                ST_READ: begin
                    // Lanes capture rd_data on the same done pulse.
                    if (rd_done) begin
                        rd_req       <= 1'b0;
                        report_start <= 1'b1;
                        state        <= ST_REPORT;
                    end else begin
                        rd_req <= 1'b1;
                    end
                end

                ST_REPORT: begin
                    if (report_done) begin
                        if (report_fail) begin
                            led   <= 1'b1;
                            state <= ST_HALT;
                        end else begin
                            state <= ST_PAUSE;
                        end
                    end
                end

                ST_PAUSE: begin
                    if (pause_cnt == PAUSE_LAST) begin
                        pause_cnt <= '0;
                        if (burst_cnt == LAST_BURST) begin
                            state <= ST_DONE;   // Frame covered.
                        end else begin
                            advance   <= 1'b1;
                            addr      <= addr + ADDR_W'(NUM_LANES);   // Next 4 words.
                            burst_cnt <= burst_cnt + 1'b1;
                            state     <= ST_WRITE;
                        end
                    end else begin
                        pause_cnt <= pause_cnt + 1'b1;
                    end
                end

                ST_DONE: begin
                    state <= ST_DONE;   // Idle until reset.
                end

                ST_HALT: begin
                    led <= 1'b1;        // Stuck on error.
                end

                default: begin
                    state <= ST_HALT;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Controller handshake checks.
    ////////////////////////////////////////////////////////////////////////////

    // Only one burst phase at a time.
    a_req_excl: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        !(wr_req && rd_req));

    // Address held for the whole request.
    a_addr_hold: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        (wr_req || rd_req) && $past(wr_req || rd_req) |-> $stable(addr));

endmodule

//--- rtl/report_serializer.sv
`timescale 1ns/1ps

module report_serializer
    import sdram_test_pkg::*;
#(
    parameter int BAUD_DIV = 1157       // Clocks per UART bit.
) (
    input  logic                 clk_133MHz_210,
    input  logic                 rst_n,
    input  logic                 report_start,              // One-cycle kick.
    input  word_t                back_words [NUM_LANES],    // Read-back words.
    input  logic [NUM_LANES-1:0] hi_match,
    input  logic [NUM_LANES-1:0] lo_match,
    output logic                 report_done,               // One-cycle strobe.
    output logic                 report_fail,               // Valid with done.
    output logic                 uart_txd
);

    localparam int BAUD_W = $clog2(BAUD_DIV + 1);
    localparam int BIT_W  = $clog2(UART_FRAME_BITS);
    localparam int IDX_W  = $clog2(BYTES_PER_BURST) + 1;
    localparam int LANE_W = $clog2(NUM_LANES);

    localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(BAUD_DIV - 1);
    localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(UART_FRAME_BITS - 1);
    localparam logic [IDX_W-1:0]  IDX_LAST  = IDX_W'(BYTES_PER_BURST - 1);

    logic                       busy;
    logic [IDX_W-1:0]           byte_idx;   // Byte on the line.
    logic [BAUD_W-1:0]          baud_cnt;
    logic [BIT_W-1:0]           bit_cnt;
    logic [UART_FRAME_BITS-1:0] tx_shift;   // LSB drives the line.
    logic                       err_sent;   // Current frame is an error code.

    logic [IDX_W-1:0]           load_idx;
    logic [LANE_W-1:0]          load_lane;
    logic                       load_hi;
    logic                       load_ok;
    logic [7:0]                 load_byte;

    ////////////////////////////////////////////////////////////////////////////
    // Next byte selection.
    ////////////////////////////////////////////////////////////////////////////

    // Order: lane 0 high, lane 0 low, lane 1 high, ...
    assign load_idx  = busy ? byte_idx + 1'b1 : '0;
    assign load_lane = load_idx[LANE_W:1];
    assign load_hi   = ~load_idx[0];                // Even index is high byte.
    assign load_ok   = load_hi ? hi_match[load_lane] : lo_match[load_lane];

    always_comb begin
        if (load_ok && load_hi) begin
            load_byte = back_words[load_lane][WORD_W-1 -: 8];
        end else if (load_ok) begin
            load_byte = back_words[load_lane][7:0];
        end else if (load_hi) begin
            load_byte = ERR_HI_CODE;                // Replaces the bad byte.
        end else begin
            load_byte = ERR_LO_CODE;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Baud, bit and byte counters with the shift register.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            byte_idx    <= '0;
            baud_cnt    <= '0;
            bit_cnt     <= '0;
            tx_shift    <= '1;                      // Line idles high.
            err_sent    <= 1'b0;
            report_done <= 1'b0;
            report_fail <= 1'b0;
        end else begin
            report_done <= 1'b0;
            report_fail <= 1'b0;
            if (!busy) begin
                if (report_start) begin
                    busy     <= 1'b1;
                    byte_idx <= '0;
                    baud_cnt <= '0;
                    bit_cnt  <= '0;
                    tx_shift <= {2'b11, load_byte, 1'b0};   // Stop, data, start.
                    err_sent <= ~load_ok;
                end
            end else if (baud_cnt != BAUD_LAST) begin
                baud_cnt <= baud_cnt + 1'b1;
            end else begin
                baud_cnt <= '0;
                if (bit_cnt != BIT_LAST) begin
                    bit_cnt  <= bit_cnt + 1'b1;
                    tx_shift <= {1'b1, tx_shift[UART_FRAME_BITS-1:1]};
                end else if (err_sent || byte_idx == IDX_LAST) begin
                    // Last frame out.
                    busy        <= 1'b0;
                    tx_shift    <= '1;
                    report_done <= 1'b1;
                    report_fail <= err_sent;
                end else begin
                    // Back to back, no idle gap.
                    bit_cnt  <= '0;
                    byte_idx <= load_idx;
                    tx_shift <= {2'b11, load_byte, 1'b0};
                    err_sent <= ~load_ok;
                end
            end
        end
    end

    assign uart_txd = tx_shift[0];

    // The walk never runs past the last byte of a burst.
    a_idx_range: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        busy |-> byte_idx < IDX_W'(BYTES_PER_BURST));

endmodule

//--- rtl/word_check_lane.sv
`timescale 1ns/1ps

module word_check_lane
    import sdram_test_pkg::*;
(
    input  logic  clk_133MHz_210,
    input  logic  rst_n,
    input  logic  advance,      // Step to next burst.
    input  logic  rd_done,      // Read-back word valid.
    input  word_t rd_word,      // Word from the controller.
    output word_t wr_word,      // Test word for this lane.
    output word_t back_word,    // Captured read-back word.
    output logic  hi_match,
    output logic  lo_match
);

    localparam int HALF_W = WORD_W / 2;   // One byte.

    ////////////////////////////////////////////////////////////////////////////
    // Test word.
    ////////////////////////////////////////////////////////////////////////////

    // Starts at zero, one step per burst.
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            wr_word <= '0;
        end else if (advance) begin
            wr_word <= wr_word + 1'b1;    // Every lane moves together.
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read-back capture.
    ////////////////////////////////////////////////////////////////////////////

    // Data is only valid in the done cycle.
    always_ff @(posedge clk_133MHz_210) begin
        if (rd_done) begin
            back_word <= rd_word;
        end
    end

    // Byte compare.
    // Checked separately so the report knows which byte failed.
    assign hi_match = (back_word[WORD_W-1:HALF_W] == wr_word[WORD_W-1:HALF_W]);
    assign lo_match = (back_word[HALF_W-1:0] == wr_word[HALF_W-1:0]);   // Low byte.

endmodule

//--- rtl/sdram_test_pkg.sv
package sdram_test_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Data path and address widths.
    ////////////////////////////////////////////////////////////////////////////
    localparam int WORD_W = 16;            // SDRAM data word.
    localparam int ADDR_W = 24;            // Bank(2) + row(13) + column(9).

    // Four-word mode of the controller.
    localparam int NUM_LANES       = 4;
    localparam int BYTES_PER_BURST = 2 * NUM_LANES;   // High and low byte per lane.

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;

    ////////////////////////////////////////////////////////////////////////////
    // Burst sequencer states.
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        ST_WRITE,       // Write request held until done.
        ST_READ,        // Read request held until done.
        ST_REPORT,      // Serializer sends the burst bytes.
        ST_PAUSE,       // Gap before the next burst.
        ST_DONE,        // Frame covered, idle.
        ST_HALT         // Compare error, led on.
    } seq_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // UART report.
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [7:0] ERR_HI_CODE = 8'hEE;   // High byte mismatch.
    localparam logic [7:0] ERR_LO_CODE = 8'hFF;   // Low byte mismatch.

    // Start bit, eight data bits LSB first, two stop bits.
    localparam int UART_FRAME_BITS = 11;

endpackage
